// File: design/cpu_pkg.sv
package cpu_pkg;

    // widths that carry a meaning
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  pc_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  cond_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [11:0] imm12_t;
    typedef logic [2:0]  alu_op_t;

    // alu operation codes
    localparam alu_op_t ALU_ADD = 3'b000;
    localparam alu_op_t ALU_SUB = 3'b001;
    localparam alu_op_t ALU_AND = 3'b010;
    localparam alu_op_t ALU_ORR = 3'b011;
    localparam alu_op_t ALU_XOR = 3'b111;

    // compare shares its low nibble with no other writing op
    localparam logic [3:0] OP_CMP_LOW = 4'b1010;
    localparam opcode_t    OP_HALT    = 7'b0101010;

    // condition 1111 is never taken and marks a bubble
    localparam cond_t  COND_NEVER   = 4'b1111;
    localparam instr_t BUBBLE_INSTR = {COND_NEVER, 28'd0};

    // instruction field positions
    localparam int COND_HI   = 31;
    localparam int COND_LO   = 28;
    localparam int OPCODE_HI = 27;
    localparam int OPCODE_LO = 21;
    localparam int S_BIT     = 20;
    localparam int RN_HI     = 19;
    localparam int RN_LO     = 16;
    localparam int RD_HI     = 15;
    localparam int RD_LO     = 12;
    localparam int IMM12_HI  = 11;
    localparam int IMM12_LO  = 0;
    localparam int SHIFT_HI  = 6;
    localparam int SHIFT_LO  = 5;
    localparam int P_BIT     = 11;
    localparam int U_BIT     = 10;
    localparam int W_BIT     = 9;
    localparam int BOFF_HI   = 20;
    localparam int BOFF_LO   = 0;

    // flags in the status word
    localparam int FLAG_N = 31;
    localparam int FLAG_Z = 30;
    localparam int FLAG_C = 29;
    localparam int FLAG_V = 28;

endpackage

// File: design/cond_check.sv
`timescale 1ns/1ps

module cond_check (
    input  cpu_pkg::cond_t cond,
    input  logic           n,
    input  logic           z,
    input  logic           c,
    input  logic           v,
    output logic           taken
);
    import cpu_pkg::*;

    // arm condition table
    always_comb begin
        taken = 1'b0;
        case (cond)
            // eq, ne
            4'b0000: taken = z;
            4'b0001: taken = !z;
            // cs, cc
            4'b0010: taken = c;
            4'b0011: taken = !c;
            // mi, pl
            4'b0100: taken = n;
            4'b0101: taken = !n;
            // vs, vc
            4'b0110: taken = v;
            4'b0111: taken = !v;
            // hi, ls
            4'b1000: taken = c && !z;
            4'b1001: taken = !c || z;
            // ge, lt
            4'b1010: taken = (n == v);
            4'b1011: taken = (n != v);
            // gt, le
            4'b1100: taken = !z && (n == v);
            4'b1101: taken = z || (n != v);
            // al
            4'b1110: taken = 1'b1;
            COND_NEVER: taken = 1'b0;
        endcase
    end

endmodule

// File: design/mem_stage_decode.sv
`timescale 1ns/1ps

module mem_stage_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::instr_t   instr_in,
    input  cpu_pkg::pc_t      pc_in,
    input  logic              branch_in,
    input  logic              branch_ref,
    output cpu_pkg::cond_t    cond,
    output cpu_pkg::opcode_t  opcode,
    output logic              en_status,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rd,
    output logic [1:0]        shift_op,
    output cpu_pkg::imm12_t   imm12,
    output logic [31:0]       imm_branch,
    output logic              P,
    output logic              U,
    output logic              W,
    output cpu_pkg::instr_t   instr_output,
    output cpu_pkg::pc_t      pc_out
);
    import cpu_pkg::*;

    instr_t stored_instr;
    pc_t    stored_pc;
    logic   stored_tag;
    logic   squash;
    instr_t eff_instr;

    // stage register holds the raw word plus the tag fetch stamped on it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stored_instr <= BUBBLE_INSTR;
            stored_pc    <= '0;
            stored_tag   <= 1'b0;
        end else begin
            stored_instr <= instr_in;
            stored_pc    <= pc_in;
            stored_tag   <= branch_in;
        end
    end

    // fetched on a path that a branch or halt has since abandoned
    assign squash    = (stored_tag != branch_ref);
    assign eff_instr = squash ? BUBBLE_INSTR : stored_instr;

    assign instr_output = eff_instr;
    assign pc_out       = stored_pc;

    // field extraction
    assign cond      = eff_instr[COND_HI:COND_LO];
    assign opcode    = eff_instr[OPCODE_HI:OPCODE_LO];
    assign en_status = eff_instr[S_BIT];
    assign rn        = eff_instr[RN_HI:RN_LO];
    assign rd        = eff_instr[RD_HI:RD_LO];
    assign shift_op  = eff_instr[SHIFT_HI:SHIFT_LO];
    assign imm12     = eff_instr[IMM12_HI:IMM12_LO];
    assign P         = eff_instr[P_BIT];
    assign U         = eff_instr[U_BIT];
    assign W         = eff_instr[W_BIT];

    // branch offset sign-extended to a full word
    assign imm_branch = {{(31 - BOFF_HI){eff_instr[BOFF_HI]}}, eff_instr[BOFF_HI:BOFF_LO]};

    // a squashed slot must look like a bubble to the controller
    a_squash_is_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        squash |-> (cond == COND_NEVER && opcode == '0 && !en_status)
    ) else $error("squashed instruction leaked fields");

endmodule

// File: design/mem_stage_ctrl.sv
`timescale 1ns/1ps

module mem_stage_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::cond_t    cond,
    input  cpu_pkg::opcode_t  opcode,
    input  logic              en_status_dec,
    input  logic              P,
    input  logic              U,
    input  logic              W,
    input  logic [31:0]       status_reg,
    output logic              branch_ref,
    output logic              branch_ref_global,
    output logic [1:0]        sel_pc,
    output logic              sel_branch_imm,
    output logic              sel_A,
    output logic              sel_B,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              sel_pre_indexed,
    output logic              en_status,
    output logic [1:0]        sel_w_addr1,
    output logic              w_en1,
    output logic              mem_w_en,
    output logic              is_halt
);
    import cpu_pkg::*;

    logic taken;
    logic is_normal;
    logic is_mem;
    logic is_branch;
    logic is_halt_op;

    cond_check u_cond_check (
        .cond  (cond),
        .n     (status_reg[FLAG_N]),
        .z     (status_reg[FLAG_Z]),
        .c     (status_reg[FLAG_C]),
        .v     (status_reg[FLAG_V]),
        .taken (taken)
    );

    // instruction classes in priority order
    assign is_normal  = !opcode[6] && (opcode[5:4] != 2'b10) && (cond != COND_NEVER);
    assign is_mem     = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
    assign is_branch  = (opcode[6:3] == 4'b1001);
    assign is_halt_op = (opcode == OP_HALT);

    always_comb begin
        sel_pc            = 2'b00;
        sel_branch_imm    = 1'b0;
        sel_A             = 1'b0;
        sel_B             = 1'b0;
        alu_op            = ALU_ADD;
        sel_pre_indexed   = 1'b0;
        en_status         = 1'b0;
        sel_w_addr1       = 2'b00;
        w_en1             = 1'b0;
        mem_w_en          = 1'b0;
        is_halt           = 1'b0;
        branch_ref_global = branch_ref;

        if (is_normal) begin
            // operand bits say where a and b load from
            sel_A = !opcode[3];
            sel_B = !opcode[4];
            case (opcode[2:0])
                3'b000:  alu_op = ALU_ADD;
                3'b001:  alu_op = ALU_SUB;
                3'b010:  alu_op = ALU_SUB;
                3'b011:  alu_op = ALU_AND;
                3'b100:  alu_op = ALU_ORR;
                3'b101:  alu_op = ALU_XOR;
                default: alu_op = ALU_ADD;
            endcase
            en_status = en_status_dec;
            // compare only sets flags
            w_en1 = (opcode[3:0] != OP_CMP_LOW);
        end else if (is_mem) begin
            // base always from rn
            sel_A           = 1'b0;
            sel_B           = !opcode[3];
            sel_pre_indexed = P;
            alu_op          = U ? ALU_ADD : ALU_SUB;
            en_status       = en_status_dec;
            // base write-back
            if (W) begin
                sel_w_addr1 = 2'b10;
                w_en1       = 1'b1;
            end
            // opcode bit 4 marks a store
            mem_w_en = opcode[4];
        end else if (is_branch) begin
            if (taken) begin
                sel_pc            = 2'b11;
                branch_ref_global = !branch_ref;
            end
            if (opcode[0]) begin
                // target held in a register
                sel_A = 1'b1;
                sel_B = 1'b0;
            end else begin
                // pc relative
                sel_B          = 1'b1;
                sel_branch_imm = 1'b1;
            end
            // link
            if (opcode[1]) begin
                sel_w_addr1 = 2'b01;
                w_en1       = 1'b1;
            end
        end else if (is_halt_op) begin
            sel_pc            = 2'b01;
            is_halt           = 1'b1;
            branch_ref_global = !branch_ref;
        end
    end

    // branch reference flips on every redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_ref <= 1'b0;
        end else begin
            branch_ref <= branch_ref_global;
        end
    end

    a_branch_no_store: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_branch |-> !(w_en1 && mem_w_en)
    ) else $error("branch enabled both register and memory writes");

    a_halt_sel_pc: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_halt |-> (sel_pc == 2'b01)
    ) else $error("halt without pc hold select");

endmodule

// File: design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::instr_t   instr_in,
    input  logic              branch_in,
    input  cpu_pkg::pc_t      pc_in,
    input  logic [31:0]       status_reg,
    // decoded fields
    output cpu_pkg::cond_t    cond,
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rd,
    output logic [1:0]        shift_op,
    output cpu_pkg::imm12_t   imm12,
    output logic [31:0]       imm_branch,
    output cpu_pkg::instr_t   instr_output,
    output cpu_pkg::pc_t      pc_out,
    // datapath selects
    output logic [1:0]        sel_pc,
    output logic              sel_branch_imm,
    output logic              sel_A,
    output logic              sel_B,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              sel_pre_indexed,
    output logic              en_status,
    output logic [1:0]        sel_w_addr1,
    output logic              w_en1,
    output logic              mem_w_en,
    output logic              is_halt,
    // next tag for fetch
    output logic              branch_ref_global
);
    logic branch_ref;
    logic en_status_dec;
    logic p_bit;
    logic u_bit;
    logic w_bit;

    mem_stage_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .pc_in        (pc_in),
        .branch_in    (branch_in),
        .branch_ref   (branch_ref),
        .cond         (cond),
        .opcode       (opcode),
        .en_status    (en_status_dec),
        .rn           (rn),
        .rd           (rd),
        .shift_op     (shift_op),
        .imm12        (imm12),
        .imm_branch   (imm_branch),
        .P            (p_bit),
        .U            (u_bit),
        .W            (w_bit),
        .instr_output (instr_output),
        .pc_out       (pc_out)
    );

    mem_stage_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .cond              (cond),
        .opcode            (opcode),
        .en_status_dec     (en_status_dec),
        .P                 (p_bit),
        .U                 (u_bit),
        .W                 (w_bit),
        .status_reg        (status_reg),
        .branch_ref        (branch_ref),
        .branch_ref_global (branch_ref_global),
        .sel_pc            (sel_pc),
        .sel_branch_imm    (sel_branch_imm),
        .sel_A             (sel_A),
        .sel_B             (sel_B),
        .alu_op            (alu_op),
        .sel_pre_indexed   (sel_pre_indexed),
        .en_status         (en_status),
        .sel_w_addr1       (sel_w_addr1),
        .w_en1             (w_en1),
        .mem_w_en          (mem_w_en),
        .is_halt           (is_halt)
    );

endmodule

// File: sim/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import cpu_pkg::*;

    localparam int HALF_PERIOD = 2;
    localparam int K_IDLE   = 0;
    localparam int K_NORMAL = 1;
    localparam int K_CMP    = 2;
    localparam int K_MEM    = 3;
    localparam int K_BRANCH = 4;
    localparam int K_HALT   = 5;
    localparam int K_MIX    = 6;

    logic        clk;
    logic        rst_n;
    instr_t      instr_in;
    logic        branch_in;
    pc_t         pc_in;
    logic [31:0] status_reg;
    cond_t       cond;
    opcode_t     opcode;
    reg_idx_t    rn;
    reg_idx_t    rd;
    logic [1:0]  shift_op;
    imm12_t      imm12;
    logic [31:0] imm_branch;
    instr_t      instr_output;
    pc_t         pc_out;
    logic [1:0]  sel_pc;
    logic        sel_branch_imm;
    logic        sel_A;
    logic        sel_B;
    alu_op_t     alu_op;
    logic        sel_pre_indexed;
    logic        en_status;
    logic [1:0]  sel_w_addr1;
    logic        w_en1;
    logic        mem_w_en;
    logic        is_halt;
    logic        branch_ref_global;

    // model of the stage register and the reference bit
    instr_t      m_instr;
    pc_t         m_pc;
    logic        m_tag;
    logic        m_ref;

    // expected values for the current cycle
    instr_t      e_instr;
    logic [1:0]  e_sel_pc;
    logic        e_branch_imm;
    logic        e_sel_a;
    logic        e_sel_b;
    alu_op_t     e_alu_op;
    logic        e_pre_indexed;
    logic        e_en_status;
    logic [1:0]  e_w_addr1;
    logic        e_w_en1;
    logic        e_mem_w_en;
    logic        e_halt;
    logic        e_ref_global;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;
    logic        timed_out;

    mem_stage i_mem_stage (.*);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // odd codes invert the even code before them
    function automatic logic cond_holds(logic [3:0] c, logic [31:0] st);
        logic base;
        case (c[3:1])
            3'd0:    base = st[30];
            3'd1:    base = st[29];
            3'd2:    base = st[31];
            3'd3:    base = st[28];
            3'd4:    base = st[29] && !st[30];
            3'd5:    base = (st[31] == st[28]);
            3'd6:    base = !st[30] && (st[31] == st[28]);
            default: base = 1'b1;
        endcase
        if (c == 4'b1111) begin
            return 1'b0;
        end
        if (c == 4'b1110) begin
            return 1'b1;
        end
        return c[0] ? !base : base;
    endfunction

    function automatic instr_t make_instr(int kind);
        int          k;
        logic [6:0]  op;
        logic [3:0]  sel;
        logic [3:0]  cnd;
        logic [20:0] rest;
        k = kind;
        if (kind == K_MIX) begin
            sel = 4'(rand_bits(4));
            if (sel < 4'd5) k = K_NORMAL;
            else if (sel < 4'd7) k = K_CMP;
            else if (sel < 4'd11) k = K_MEM;
            else if (sel < 4'd15) k = K_BRANCH;
            else k = K_HALT;
        end
        case (k)
            K_NORMAL: begin
                op = 7'(rand_bits(7));
                op[6] = 1'b0;
                if (op[5:4] == 2'b10) op[5:4] = 2'b00;
            end
            K_CMP: begin
                op = {1'b0, 2'(rand_bits(2)), OP_CMP_LOW};
                if (op[5:4] == 2'b10) op[5:4] = 2'b11;
            end
            K_MEM: begin
                if (rand_bits(1) != 32'd0) op = {2'b11, 5'(rand_bits(5))};
                else op = {4'b1000, 3'(rand_bits(3))};
            end
            K_BRANCH: op = {4'b1001, 3'(rand_bits(3))};
            default:  op = OP_HALT;
        endcase
        cnd  = 4'(rand_bits(4));
        rest = 21'(rand_bits(21));
        if (k == K_IDLE) begin
            return BUBBLE_INSTR;
        end
        return {cnd, op, rest};
    endfunction

    task automatic predict;
        logic [6:0] op;
        logic [3:0] cnd;
        e_instr = (m_tag != m_ref) ? BUBBLE_INSTR : m_instr;
        cnd = e_instr[31:28];
        op  = e_instr[27:21];
        e_sel_pc = 2'b00;
        e_branch_imm = 1'b0;
        e_sel_a = 1'b0;
        e_sel_b = 1'b0;
        e_alu_op = ALU_ADD;
        e_pre_indexed = 1'b0;
        e_en_status = 1'b0;
        e_w_addr1 = 2'b00;
        e_w_en1 = 1'b0;
        e_mem_w_en = 1'b0;
        e_halt = 1'b0;
        e_ref_global = m_ref;
        if (op[6:3] == 4'b1001) begin
            if (cond_holds(cnd, status_reg)) begin
                e_sel_pc = 2'b11;
                e_ref_global = !m_ref;
            end
            e_sel_a = op[0];
            e_sel_b = !op[0];
            e_branch_imm = !op[0];
            e_w_addr1 = op[1] ? 2'b01 : 2'b00;
            e_w_en1 = op[1];
        end else if (op == OP_HALT) begin
            e_sel_pc = 2'b01;
            e_halt = 1'b1;
            e_ref_global = !m_ref;
        end else if (op[6:5] == 2'b11 || op[6:3] == 4'b1000) begin
            e_sel_b = !op[3];
            e_pre_indexed = e_instr[11];
            e_alu_op = e_instr[10] ? ALU_ADD : ALU_SUB;
            e_en_status = e_instr[20];
            e_w_addr1 = e_instr[9] ? 2'b10 : 2'b00;
            e_w_en1 = e_instr[9];
            e_mem_w_en = op[4];
        end else if (!op[6] && op[5:4] != 2'b10 && cnd != 4'b1111) begin
            e_sel_a = !op[3];
            e_sel_b = !op[4];
            case (op[2:0])
                3'b001, 3'b010: e_alu_op = ALU_SUB;
                3'b011:         e_alu_op = ALU_AND;
                3'b100:         e_alu_op = ALU_ORR;
                3'b101:         e_alu_op = ALU_XOR;
                default:        e_alu_op = ALU_ADD;
            endcase
            e_en_status = e_instr[20];
            e_w_en1 = (op[3:0] != OP_CMP_LOW);
        end
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %t: %s is %h, expected %h", $realtime, name, got, expected);
        end
    endtask

    task automatic check_outputs;
        check_val("instr_output", instr_output, e_instr);
        check_val("pc_out", 32'(pc_out), 32'(m_pc));
        check_val("cond", 32'(cond), 32'(e_instr[31:28]));
        check_val("opcode", 32'(opcode), 32'(e_instr[27:21]));
        check_val("rn", 32'(rn), 32'(e_instr[19:16]));
        check_val("rd", 32'(rd), 32'(e_instr[15:12]));
        check_val("shift_op", 32'(shift_op), 32'(e_instr[6:5]));
        check_val("imm12", 32'(imm12), 32'(e_instr[11:0]));
        check_val("imm_branch", imm_branch, {{11{e_instr[20]}}, e_instr[20:0]});
        check_val("sel_pc", 32'(sel_pc), 32'(e_sel_pc));
        check_val("sel_branch_imm", 32'(sel_branch_imm), 32'(e_branch_imm));
        check_val("sel_A", 32'(sel_A), 32'(e_sel_a));
        check_val("sel_B", 32'(sel_B), 32'(e_sel_b));
        check_val("alu_op", 32'(alu_op), 32'(e_alu_op));
        check_val("sel_pre_indexed", 32'(sel_pre_indexed), 32'(e_pre_indexed));
        check_val("en_status", 32'(en_status), 32'(e_en_status));
        check_val("sel_w_addr1", 32'(sel_w_addr1), 32'(e_w_addr1));
        check_val("w_en1", 32'(w_en1), 32'(e_w_en1));
        check_val("mem_w_en", 32'(mem_w_en), 32'(e_mem_w_en));
        check_val("is_halt", 32'(is_halt), 32'(e_halt));
        check_val("branch_ref_global", 32'(branch_ref_global), 32'(e_ref_global));
    endtask

    // samples in half-period steps from odd times, never on an edge
    task automatic next_rise;
        int guard;
        guard = 0;
        while (clk !== 1'b0 && guard < 4) begin
            #(HALF_PERIOD);
            guard++;
        end
        while (clk !== 1'b1 && guard < 4) begin
            #(HALF_PERIOD);
            guard++;
        end
        if (guard >= 4) begin
            timed_out = 1'b1;
            $display("timeout: no rising clock edge within two periods");
        end
    endtask

    task automatic wait_reset_clear;
        int guard;
        guard = 0;
        while ((instr_output !== BUBBLE_INSTR || branch_ref_global !== 1'b0) && guard < 8) begin
            #(2 * HALF_PERIOD);
            guard++;
        end
        if (guard >= 8) begin
            timed_out = 1'b1;
            $display("timeout: stage did not show a bubble after reset");
        end
    endtask

    task automatic run_test(string name, int kind, int cycles, logic stale_on);
        int errors_before;
        int n;
        errors_before = errors;
        n = 0;
        while (n < cycles && !timed_out) begin
            status_reg = {4'(rand_bits(4)), 28'd0};
            predict();
            instr_in  = make_instr(kind);
            pc_in     = 7'(rand_bits(7));
            branch_in = e_ref_global;
            // as if fetched before the last redirect
            if (stale_on && rand_bits(3) == 32'd0) begin
                branch_in = !e_ref_global;
            end
            #(HALF_PERIOD);
            check_outputs();
            next_rise();
            // what the stage captured at that edge
            m_ref   = e_ref_global;
            m_instr = instr_in;
            m_pc    = pc_in;
            m_tag   = branch_in;
            n++;
        end
        tests++;
        $display("test %-8s %0d cycles, %0d errors", name, n, errors - errors_before);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        lfsr = 32'd36;
        errors = 0;
        checks = 0;
        tests = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        instr_in = BUBBLE_INSTR;
        pc_in = '0;
        branch_in = 1'b0;
        status_reg = '0;
        m_instr = BUBBLE_INSTR;
        m_pc = '0;
        m_tag = 1'b0;
        m_ref = 1'b0;
        #1;
        next_rise();
        next_rise();
        rst_n = 1'b1;
        wait_reset_clear();
        run_test("reset", K_IDLE, 2, 1'b0);
        run_test("normal", K_NORMAL, 40, 1'b0);
        run_test("compare", K_CMP, 20, 1'b0);
        run_test("memory", K_MEM, 48, 1'b0);
        run_test("branch", K_BRANCH, 64, 1'b0);
        run_test("stale", K_MIX, 60, 1'b1);
        run_test("halt", K_HALT, 12, 1'b0);
        run_test("mixed", K_MIX, 200, 1'b1);
        $display("%0d tests, %0d checks, %0d errors%s", tests, checks, errors,
                 timed_out ? ", run timed out" : "");
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
design/cpu_pkg.sv
design/cond_check.sv
design/mem_stage_decode.sv
design/mem_stage_ctrl.sv
design/mem_stage.sv
sim/tb_mem_stage.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_stage \
    -f files.f -Mdir obj_dir -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
